//--- uce_config.svh
// UCE cache controller configuration
// Address, cache geometry, beat sizes and the memory credit limit
`ifndef UCE_CONFIG_SVH
`define UCE_CONFIG_SVH

`define UCE_PADDR_WIDTH 32

// Cache geometry
`define UCE_SETS 8
`define UCE_INDEX_WIDTH $clog2(`UCE_SETS)
`define UCE_ASSOC 2
`define UCE_WAY_WIDTH $clog2(`UCE_ASSOC)

// One memory beat carries one dword
`define UCE_FILL_WIDTH 64
`define UCE_DWORD_WIDTH 64
`define UCE_BLOCK_BEATS 4
`define UCE_BEAT_WIDTH $clog2(`UCE_BLOCK_BEATS)
`define UCE_BLOCK_OFFSET_WIDTH 5
`define UCE_TAG_WIDTH (`UCE_PADDR_WIDTH - `UCE_INDEX_WIDTH - `UCE_BLOCK_OFFSET_WIDTH)

`define UCE_MAX_CREDITS 4
`define UCE_CREDIT_WIDTH $clog2(`UCE_MAX_CREDITS + 1)

`endif

//--- uce_pkg.sv
// UCE shared types
// Request kinds, memory message kinds, tag and data memory opcodes
// and the control states of the request FSM
package uce_pkg;

  typedef enum logic [1:0]
  {
    e_req_miss_load
    , e_req_uc_load
    , e_req_uc_store
    , e_req_clear
  } uce_req_type_e;

  // Forward and reverse messages share the same encoding
  typedef enum logic [1:0]
  {
    e_mem_rd
    , e_mem_uc_rd
    , e_mem_uc_wr
  } uce_mem_msg_e;

  // set_tag always installs the line in M
  typedef enum logic [1:0]
  {
    e_tag_set_clear
    , e_tag_set_tag
  } uce_tag_op_e;

  typedef enum logic [1:0]
  {
    e_data_write
    , e_data_uncached
  } uce_data_op_e;

  typedef enum logic [2:0]
  {
    e_reset
    , e_clear
    , e_ready
    , e_send
    , e_wait
  } uce_state_e;

endpackage

//--- uce_req_decode.sv
// UCE request decode
// Takes cache requests, holds the accepted one and runs the control FSM.
// Maps the request to a memory message and starts the tag clear sweep.
`timescale 1ns/1ps
`include "uce_config.svh"

module uce_req_decode
  (input  logic                               clk_i
   , input  logic                             reset_i
   , input  logic                             cache_req_v_i
   , input  uce_pkg::uce_req_type_e           cache_req_type_i
   , input  logic [`UCE_PADDR_WIDTH-1:0]      cache_req_addr_i
   , input  logic [`UCE_DWORD_WIDTH-1:0]      cache_req_data_i
   , input  logic [`UCE_WAY_WIDTH-1:0]        cache_req_way_i
   , input  logic                             issue_done_i
   , input  logic                             sweep_done_i
   , input  logic                             fill_done_i
   , output logic                             cache_req_yumi_o
   , output logic                             busy_o
   , output logic                             issue_v_o
   , output uce_pkg::uce_mem_msg_e            issue_msg_o
   , output logic [`UCE_PADDR_WIDTH-1:0]      issue_addr_o
   , output logic [`UCE_DWORD_WIDTH-1:0]      issue_data_o
   , output logic [`UCE_WAY_WIDTH-1:0]        issue_way_o
   , output logic                             clear_start_o
   );

  import uce_pkg::*;

  uce_state_e state_r, state_n;
  uce_req_type_e req_type_r;
  logic [`UCE_PADDR_WIDTH-1:0] req_addr_r;
  logic [`UCE_DWORD_WIDTH-1:0] req_data_r;
  logic [`UCE_WAY_WIDTH-1:0] req_way_r;
  logic store_pend_r;
  logic clear_start_r;

  wire is_ready = (state_r == e_ready);
  wire is_send = (state_r == e_send);

  // Stores go out from e_ready, so the slot frees up the cycle one transfers
  assign cache_req_yumi_o = is_ready & cache_req_v_i & (~store_pend_r | issue_done_i);
  assign busy_o = (state_r == e_reset) | (state_r == e_clear);
  assign issue_v_o = is_send | (is_ready & store_pend_r);
  assign clear_start_o = clear_start_r;

  always_comb
  begin
    case (req_type_r)
      e_req_miss_load: issue_msg_o = e_mem_rd;
      e_req_uc_load:   issue_msg_o = e_mem_uc_rd;
      default:         issue_msg_o = e_mem_uc_wr;
    endcase
  end

  // Misses fetch the whole block
  assign issue_addr_o = (req_type_r == e_req_miss_load)
                        ? {req_addr_r[`UCE_PADDR_WIDTH-1:`UCE_BLOCK_OFFSET_WIDTH],
                           `UCE_BLOCK_OFFSET_WIDTH'(0)}
                        : req_addr_r;
  assign issue_data_o = req_data_r;
  assign issue_way_o = req_way_r;

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_reset: state_n = e_clear;
      e_clear: if (sweep_done_i) state_n = e_ready;
      e_ready:
        if (cache_req_yumi_o)
        begin
          case (cache_req_type_i)
            e_req_clear:    state_n = e_clear;
            e_req_uc_store: state_n = e_ready;
            default:        state_n = e_send;
          endcase
        end
      e_send: if (issue_done_i) state_n = e_wait;
      e_wait: if (fill_done_i) state_n = e_ready;
      default: state_n = e_reset;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_reset;
      store_pend_r <= 1'b0;
      clear_start_r <= 1'b0;
    end
    else
    begin
      state_r <= state_n;
      store_pend_r <= (cache_req_yumi_o & (cache_req_type_i == e_req_uc_store))
                      | (store_pend_r & ~issue_done_i);
      clear_start_r <= (state_n == e_clear) & (state_r != e_clear);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cache_req_yumi_o)
    begin
      req_type_r <= cache_req_type_i;
      req_addr_r <= cache_req_addr_i;
      req_data_r <= cache_req_data_i;
      req_way_r <= cache_req_way_i;
    end
  end

endmodule

//--- uce_fwd_issue.sv
// UCE forward issue
// Sends one-beat memory forward messages for the decode unit and
// counts outstanding messages against the credit limit.
`timescale 1ns/1ps
`include "uce_config.svh"

module uce_fwd_issue
  (input  logic                               clk_i
   , input  logic                             reset_i
   , input  logic                             issue_v_i
   , input  uce_pkg::uce_mem_msg_e            issue_msg_i
   , input  logic [`UCE_PADDR_WIDTH-1:0]      issue_addr_i
   , input  logic [`UCE_DWORD_WIDTH-1:0]      issue_data_i
   , input  logic [`UCE_WAY_WIDTH-1:0]        issue_way_i
   , input  logic                             mem_fwd_ready_and_i
   , input  logic                             rev_last_ack_i
   , output logic                             issue_done_o
   , output logic                             mem_fwd_v_o
   , output uce_pkg::uce_mem_msg_e            mem_fwd_msg_o
   , output logic [`UCE_PADDR_WIDTH-1:0]      mem_fwd_addr_o
   , output logic [`UCE_FILL_WIDTH-1:0]       mem_fwd_data_o
   , output logic [`UCE_WAY_WIDTH-1:0]        mem_fwd_way_o
   , output logic                             credits_full_o
   , output logic                             credits_empty_o
   );

  import uce_pkg::*;

  logic [`UCE_CREDIT_WIDTH-1:0] credit_r;
  logic credit_up;
  logic credit_down;

  assign credits_full_o = (credit_r == `UCE_MAX_CREDITS);
  assign credits_empty_o = (credit_r == 0);

  // Hold the message off while every credit is in use
  assign mem_fwd_v_o = issue_v_i & ~credits_full_o;
  assign issue_done_o = mem_fwd_v_o & mem_fwd_ready_and_i;

  always_comb
  begin
    mem_fwd_msg_o = issue_msg_i;
    mem_fwd_addr_o = issue_addr_i;
    mem_fwd_way_o = issue_way_i;
    // Only stores carry a payload
    if (issue_msg_i == e_mem_uc_wr)
      mem_fwd_data_o = `UCE_FILL_WIDTH'(issue_data_i);
    else
      mem_fwd_data_o = '0;
  end

  // One credit per message, returned with the last response beat
  assign credit_up = issue_done_o;
  assign credit_down = rev_last_ack_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      credit_r <= '0;
    else if (credit_up & ~credit_down)
      credit_r <= credit_r + 1'b1;
    else if (credit_down & ~credit_up)
      credit_r <= credit_r - 1'b1;
  end

endmodule

//--- uce_fill_writer.sv
// UCE fill writer
// Sweeps the tag memory clear set by set, writes returning fill beats
// with their tag, returns uncached load data and takes store responses.
`timescale 1ns/1ps
`include "uce_config.svh"

module uce_fill_writer
  (input  logic                               clk_i
   , input  logic                             reset_i
   , input  logic                             clear_start_i
   , input  logic                             mem_rev_v_i
   , input  uce_pkg::uce_mem_msg_e            mem_rev_msg_i
   , input  logic [`UCE_PADDR_WIDTH-1:0]      mem_rev_addr_i
   , input  logic [`UCE_WAY_WIDTH-1:0]        mem_rev_way_i
   , input  logic [`UCE_FILL_WIDTH-1:0]       mem_rev_data_i
   , input  logic                             mem_rev_last_i
   , input  logic                             tag_mem_yumi_i
   , input  logic                             data_mem_yumi_i
   , output logic                             mem_rev_ready_and_o
   , output logic                             rev_last_ack_o
   , output logic                             sweep_done_o
   , output logic                             fill_done_o
   , output logic                             tag_mem_v_o
   , output uce_pkg::uce_tag_op_e             tag_mem_op_o
   , output logic [`UCE_INDEX_WIDTH-1:0]      tag_mem_index_o
   , output logic [`UCE_WAY_WIDTH-1:0]        tag_mem_way_o
   , output logic [`UCE_TAG_WIDTH-1:0]        tag_mem_tag_o
   , output logic                             data_mem_v_o
   , output uce_pkg::uce_data_op_e            data_mem_op_o
   , output logic [`UCE_INDEX_WIDTH-1:0]      data_mem_index_o
   , output logic [`UCE_WAY_WIDTH-1:0]        data_mem_way_o
   , output logic [`UCE_BEAT_WIDTH-1:0]       data_mem_beat_o
   , output logic [`UCE_FILL_WIDTH-1:0]       data_mem_data_o
   );

  import uce_pkg::*;

  logic sweep_active_r;
  logic [`UCE_INDEX_WIDTH-1:0] set_cnt_r;
  logic [`UCE_BEAT_WIDTH-1:0] beat_cnt_r;
  logic tag_sent_r;
  logic data_sent_r;

  wire [`UCE_INDEX_WIDTH-1:0] rev_index = mem_rev_addr_i[`UCE_BLOCK_OFFSET_WIDTH +: `UCE_INDEX_WIDTH];
  wire [`UCE_TAG_WIDTH-1:0] rev_tag =
    mem_rev_addr_i[`UCE_BLOCK_OFFSET_WIDTH + `UCE_INDEX_WIDTH +: `UCE_TAG_WIDTH];

  wire rd_beat_v = mem_rev_v_i & (mem_rev_msg_i == e_mem_rd) & ~sweep_active_r;
  wire uc_beat_v = mem_rev_v_i & (mem_rev_msg_i == e_mem_uc_rd);
  wire st_beat_v = mem_rev_v_i & (mem_rev_msg_i == e_mem_uc_wr);
  wire sweep_last = (set_cnt_r == `UCE_SETS - 1);

  // A fill beat retires once both its tag and data packets are taken,
  // possibly in different cycles
  wire tag_ok = tag_sent_r | tag_mem_yumi_i;
  wire data_ok = data_sent_r | data_mem_yumi_i;
  wire rd_ack = rd_beat_v & tag_ok & data_ok;
  wire uc_ack = uc_beat_v & data_mem_yumi_i;

  assign mem_rev_ready_and_o = st_beat_v | rd_ack | uc_ack;
  assign rev_last_ack_o = mem_rev_ready_and_o & mem_rev_last_i;
  assign fill_done_o = (rd_ack | uc_ack) & mem_rev_last_i;
  assign sweep_done_o = sweep_active_r & tag_mem_yumi_i & sweep_last;

  always_comb
  begin
    if (sweep_active_r)
    begin
      tag_mem_v_o = 1'b1;
      tag_mem_op_o = e_tag_set_clear;
      tag_mem_index_o = set_cnt_r;
      tag_mem_way_o = '0;
      tag_mem_tag_o = '0;
    end
    else
    begin
      tag_mem_v_o = rd_beat_v & ~tag_sent_r;
      tag_mem_op_o = e_tag_set_tag;
      tag_mem_index_o = rev_index;
      tag_mem_way_o = mem_rev_way_i;
      tag_mem_tag_o = rev_tag;
    end
  end

  always_comb
  begin
    data_mem_v_o = (rd_beat_v & ~data_sent_r) | uc_beat_v;
    data_mem_index_o = rev_index;
    data_mem_way_o = mem_rev_way_i;
    data_mem_beat_o = beat_cnt_r;
    if (uc_beat_v)
    begin
      data_mem_op_o = e_data_uncached;
      data_mem_data_o = {(`UCE_FILL_WIDTH / `UCE_DWORD_WIDTH){mem_rev_data_i[0 +: `UCE_DWORD_WIDTH]}};
    end
    else
    begin
      data_mem_op_o = e_data_write;
      data_mem_data_o = mem_rev_data_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      sweep_active_r <= 1'b0;
      set_cnt_r <= '0;
    end
    else if (clear_start_i)
    begin
      sweep_active_r <= 1'b1;
      set_cnt_r <= '0;
    end
    else if (sweep_active_r & tag_mem_yumi_i)
    begin
      set_cnt_r <= set_cnt_r + 1'b1;
      if (sweep_last)
        sweep_active_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      beat_cnt_r <= '0;
      tag_sent_r <= 1'b0;
      data_sent_r <= 1'b0;
    end
    else
    begin
      tag_sent_r <= ~rd_ack & (tag_sent_r | (rd_beat_v & tag_mem_yumi_i));
      data_sent_r <= ~rd_ack & (data_sent_r | (rd_beat_v & data_mem_yumi_i));
      if (rd_ack)
        beat_cnt_r <= mem_rev_last_i ? '0 : beat_cnt_r + 1'b1;
    end
  end

endmodule

//--- uce_top.sv
// UCE cache controller top
// Connects request decode, forward issue and fill writer between the
// cache request port, the tag and data memories and the memory network
`timescale 1ns/1ps
`include "uce_config.svh"

module uce_top
  (input  logic                               clk_i
   , input  logic                             reset_i
   , input  logic                             cache_req_v_i
   , input  uce_pkg::uce_req_type_e           cache_req_type_i
   , input  logic [`UCE_PADDR_WIDTH-1:0]      cache_req_addr_i
   , input  logic [`UCE_DWORD_WIDTH-1:0]      cache_req_data_i
   , input  logic [`UCE_WAY_WIDTH-1:0]        cache_req_way_i
   , output logic                             cache_req_yumi_o
   , output logic                             cache_req_busy_o
   , output logic                             cache_req_complete_o
   , output logic                             cache_req_credits_full_o
   , output logic                             cache_req_credits_empty_o
   , output logic                             tag_mem_v_o
   , output uce_pkg::uce_tag_op_e             tag_mem_op_o
   , output logic [`UCE_INDEX_WIDTH-1:0]      tag_mem_index_o
   , output logic [`UCE_WAY_WIDTH-1:0]        tag_mem_way_o
   , output logic [`UCE_TAG_WIDTH-1:0]        tag_mem_tag_o
   , input  logic                             tag_mem_yumi_i
   , output logic                             data_mem_v_o
   , output uce_pkg::uce_data_op_e            data_mem_op_o
   , output logic [`UCE_INDEX_WIDTH-1:0]      data_mem_index_o
   , output logic [`UCE_WAY_WIDTH-1:0]        data_mem_way_o
   , output logic [`UCE_BEAT_WIDTH-1:0]       data_mem_beat_o
   , output logic [`UCE_FILL_WIDTH-1:0]       data_mem_data_o
   , input  logic                             data_mem_yumi_i
   , output logic                             mem_fwd_v_o
   , output uce_pkg::uce_mem_msg_e            mem_fwd_msg_o
   , output logic [`UCE_PADDR_WIDTH-1:0]      mem_fwd_addr_o
   , output logic [`UCE_FILL_WIDTH-1:0]       mem_fwd_data_o
   , output logic [`UCE_WAY_WIDTH-1:0]        mem_fwd_way_o
   , input  logic                             mem_fwd_ready_and_i
   , input  logic                             mem_rev_v_i
   , input  uce_pkg::uce_mem_msg_e            mem_rev_msg_i
   , input  logic [`UCE_PADDR_WIDTH-1:0]      mem_rev_addr_i
   , input  logic [`UCE_WAY_WIDTH-1:0]        mem_rev_way_i
   , input  logic [`UCE_FILL_WIDTH-1:0]       mem_rev_data_i
   , input  logic                             mem_rev_last_i
   , output logic                             mem_rev_ready_and_o
   );

  import uce_pkg::*;

  logic issue_v;
  uce_mem_msg_e issue_msg;
  logic [`UCE_PADDR_WIDTH-1:0] issue_addr;
  logic [`UCE_DWORD_WIDTH-1:0] issue_data;
  logic [`UCE_WAY_WIDTH-1:0] issue_way;
  logic issue_done;
  logic clear_start;
  logic sweep_done;
  logic fill_done;
  logic rev_last_ack;
  logic decode_busy;

  // Busy also covers a full credit counter
  assign cache_req_busy_o = decode_busy | cache_req_credits_full_o;
  assign cache_req_complete_o = fill_done;

  uce_req_decode decode
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.cache_req_v_i(cache_req_v_i)
     ,.cache_req_type_i(cache_req_type_i)
     ,.cache_req_addr_i(cache_req_addr_i)
     ,.cache_req_data_i(cache_req_data_i)
     ,.cache_req_way_i(cache_req_way_i)
     ,.issue_done_i(issue_done)
     ,.sweep_done_i(sweep_done)
     ,.fill_done_i(fill_done)
     ,.cache_req_yumi_o(cache_req_yumi_o)
     ,.busy_o(decode_busy)
     ,.issue_v_o(issue_v)
     ,.issue_msg_o(issue_msg)
     ,.issue_addr_o(issue_addr)
     ,.issue_data_o(issue_data)
     ,.issue_way_o(issue_way)
     ,.clear_start_o(clear_start)
     );

  uce_fwd_issue execute
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.issue_v_i(issue_v)
     ,.issue_msg_i(issue_msg)
     ,.issue_addr_i(issue_addr)
     ,.issue_data_i(issue_data)
     ,.issue_way_i(issue_way)
     ,.mem_fwd_ready_and_i(mem_fwd_ready_and_i)
     ,.rev_last_ack_i(rev_last_ack)
     ,.issue_done_o(issue_done)
     ,.mem_fwd_v_o(mem_fwd_v_o)
     ,.mem_fwd_msg_o(mem_fwd_msg_o)
     ,.mem_fwd_addr_o(mem_fwd_addr_o)
     ,.mem_fwd_data_o(mem_fwd_data_o)
     ,.mem_fwd_way_o(mem_fwd_way_o)
     ,.credits_full_o(cache_req_credits_full_o)
     ,.credits_empty_o(cache_req_credits_empty_o)
     );

  uce_fill_writer result
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.clear_start_i(clear_start)
     ,.mem_rev_v_i(mem_rev_v_i)
     ,.mem_rev_msg_i(mem_rev_msg_i)
     ,.mem_rev_addr_i(mem_rev_addr_i)
     ,.mem_rev_way_i(mem_rev_way_i)
     ,.mem_rev_data_i(mem_rev_data_i)
     ,.mem_rev_last_i(mem_rev_last_i)
     ,.tag_mem_yumi_i(tag_mem_yumi_i)
     ,.data_mem_yumi_i(data_mem_yumi_i)
     ,.mem_rev_ready_and_o(mem_rev_ready_and_o)
     ,.rev_last_ack_o(rev_last_ack)
     ,.sweep_done_o(sweep_done)
     ,.fill_done_o(fill_done)
     ,.tag_mem_v_o(tag_mem_v_o)
     ,.tag_mem_op_o(tag_mem_op_o)
     ,.tag_mem_index_o(tag_mem_index_o)
     ,.tag_mem_way_o(tag_mem_way_o)
     ,.tag_mem_tag_o(tag_mem_tag_o)
     ,.data_mem_v_o(data_mem_v_o)
     ,.data_mem_op_o(data_mem_op_o)
     ,.data_mem_index_o(data_mem_index_o)
     ,.data_mem_way_o(data_mem_way_o)
     ,.data_mem_beat_o(data_mem_beat_o)
     ,.data_mem_data_o(data_mem_data_o)
     );

endmodule

//--- tb_uce.sv
// UCE cache controller testbench
// Runs the tag clear sweep, miss loads, uncached loads and store bursts
// against a memory model with random response delays and back-pressure.
`timescale 1ns/1ps
`include "uce_config.svh"

module tb_uce;

  import uce_pkg::*;

  localparam int unsigned SEED = 32'h987342fc;
  localparam int MAX_CYCLES = 20000;

  typedef struct packed
  {
    uce_mem_msg_e msg;
    logic [`UCE_PADDR_WIDTH-1:0] addr;
    logic [`UCE_DWORD_WIDTH-1:0] data;
    logic [`UCE_WAY_WIDTH-1:0] way;
  } fwd_msg_t;

  logic clk_i;
  logic reset_i;
  logic cache_req_v_i;
  uce_req_type_e cache_req_type_i;
  logic [`UCE_PADDR_WIDTH-1:0] cache_req_addr_i;
  logic [`UCE_DWORD_WIDTH-1:0] cache_req_data_i;
  logic [`UCE_WAY_WIDTH-1:0] cache_req_way_i;
  logic cache_req_yumi_o;
  logic cache_req_busy_o;
  logic cache_req_complete_o;
  logic cache_req_credits_full_o;
  logic cache_req_credits_empty_o;
  logic tag_mem_v_o;
  uce_tag_op_e tag_mem_op_o;
  logic [`UCE_INDEX_WIDTH-1:0] tag_mem_index_o;
  logic [`UCE_WAY_WIDTH-1:0] tag_mem_way_o;
  logic [`UCE_TAG_WIDTH-1:0] tag_mem_tag_o;
  logic tag_mem_yumi_i;
  logic data_mem_v_o;
  uce_data_op_e data_mem_op_o;
  logic [`UCE_INDEX_WIDTH-1:0] data_mem_index_o;
  logic [`UCE_WAY_WIDTH-1:0] data_mem_way_o;
  logic [`UCE_BEAT_WIDTH-1:0] data_mem_beat_o;
  logic [`UCE_FILL_WIDTH-1:0] data_mem_data_o;
  logic data_mem_yumi_i;
  logic mem_fwd_v_o;
  uce_mem_msg_e mem_fwd_msg_o;
  logic [`UCE_PADDR_WIDTH-1:0] mem_fwd_addr_o;
  logic [`UCE_FILL_WIDTH-1:0] mem_fwd_data_o;
  logic [`UCE_WAY_WIDTH-1:0] mem_fwd_way_o;
  logic mem_fwd_ready_and_i;
  logic mem_rev_v_i;
  uce_mem_msg_e mem_rev_msg_i;
  logic [`UCE_PADDR_WIDTH-1:0] mem_rev_addr_i;
  logic [`UCE_WAY_WIDTH-1:0] mem_rev_way_i;
  logic [`UCE_FILL_WIDTH-1:0] mem_rev_data_i;
  logic mem_rev_last_i;
  logic mem_rev_ready_and_o;

  int errors = 0;
  int req_count = 0;
  int cycle_count = 0;
  int unsigned seed_val;
  logic stall_mode = 1'b0;
  logic long_delay = 1'b0;

  // Expected forward messages, in issue order
  fwd_msg_t exp_fwd_q[$];
  fwd_msg_t mon_fwd;
  logic [`UCE_PADDR_WIDTH-1:0] cur_addr = '0;
  logic [`UCE_WAY_WIDTH-1:0] cur_way = '0;

  // Counts kept by the checker
  int clear_cnt = 0;
  int tag_wr_cnt = 0;
  int data_wr_cnt = 0;
  int uc_cnt = 0;
  int complete_cnt = 0;
  int store_resp_cnt = 0;
  int full_seen = 0;
  int outstanding = 0;

  // Memory model state
  fwd_msg_t job_q[$];
  int unsigned due_q[$];
  fwd_msg_t cur_job;
  logic rev_busy = 1'b0;
  int rev_beat = 0;

  uce_top uut (.*);

  always #10 clk_i = ~clk_i;

  // Memory contents depend on every address bit
  function automatic logic [`UCE_DWORD_WIDTH-1:0] mem_contents(logic [31:0] addr);
    mem_contents = {addr ^ 32'hc3a5_0f1e, addr * 32'h9e37_79b9};
  endfunction

  function automatic logic [31:0] block_of(logic [31:0] addr);
    block_of = {addr[`UCE_PADDR_WIDTH-1:`UCE_BLOCK_OFFSET_WIDTH], `UCE_BLOCK_OFFSET_WIDTH'(0)};
  endfunction

  function automatic logic [`UCE_FILL_WIDTH-1:0] expect_fill_beat(logic [31:0] addr, int beat);
    expect_fill_beat = mem_contents(block_of(addr) + 32'(beat * (`UCE_DWORD_WIDTH / 8)));
  endfunction

  function automatic logic [`UCE_FILL_WIDTH-1:0] expect_uncached(logic [31:0] addr);
    expect_uncached = {(`UCE_FILL_WIDTH / `UCE_DWORD_WIDTH){mem_contents(addr)}};
  endfunction

  function automatic logic [`UCE_INDEX_WIDTH-1:0] expect_index(logic [31:0] addr);
    expect_index = addr[`UCE_BLOCK_OFFSET_WIDTH +: `UCE_INDEX_WIDTH];
  endfunction

  function automatic logic [`UCE_TAG_WIDTH-1:0] expect_tag(logic [31:0] addr);
    expect_tag = addr[`UCE_PADDR_WIDTH-1:`UCE_BLOCK_OFFSET_WIDTH + `UCE_INDEX_WIDTH];
  endfunction

  task automatic report_mismatch(string name, logic [63:0] expected, logic [63:0] actual);
    errors++;
    $display("FAIL %0t: %s expected %h got %h", $time, name, expected, actual);
  endtask

  always @(posedge clk_i)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == MAX_CYCLES)
    begin
      $display("ERROR: run stopped after %0d cycles without finishing", MAX_CYCLES);
      $display("Finished with errors");
      $finish;
    end
  end

  // Memory model with random back-pressure and response delays
  always @(posedge clk_i)
  begin
    mem_fwd_ready_and_i <= stall_mode ? ($urandom_range(3) != 0) : 1'b1;
    tag_mem_yumi_i <= stall_mode ? ($urandom_range(3) != 0) : 1'b1;
    data_mem_yumi_i <= stall_mode ? ($urandom_range(3) != 0) : 1'b1;
    if (reset_i)
    begin
      mem_rev_v_i <= 1'b0;
      rev_busy = 1'b0;
    end
    else
    begin
      if (mem_fwd_v_o && mem_fwd_ready_and_i)
      begin
        job_q.push_back({mem_fwd_msg_o, mem_fwd_addr_o, mem_fwd_data_o, mem_fwd_way_o});
        due_q.push_back(cycle_count + (long_delay ? $urandom_range(24, 16) : $urandom_range(8, 1)));
      end
      if (rev_busy && mem_rev_ready_and_o)
      begin
        if (mem_rev_last_i)
        begin
          rev_busy = 1'b0;
          mem_rev_v_i <= 1'b0;
        end
        else
        begin
          rev_beat++;
          mem_rev_data_i <= mem_contents(cur_job.addr + 32'(rev_beat * 8));
          mem_rev_last_i <= (rev_beat == `UCE_BLOCK_BEATS - 1);
        end
      end
      if (!rev_busy && job_q.size() != 0 && cycle_count >= due_q[0])
      begin
        cur_job = job_q.pop_front();
        due_q.delete(0);
        rev_busy = 1'b1;
        rev_beat = 0;
        mem_rev_v_i <= 1'b1;
        mem_rev_msg_i <= cur_job.msg;
        mem_rev_addr_i <= cur_job.addr;
        mem_rev_way_i <= cur_job.way;
        mem_rev_data_i <= (cur_job.msg == e_mem_uc_wr) ? '0 : mem_contents(cur_job.addr);
        mem_rev_last_i <= (cur_job.msg != e_mem_rd);
      end
    end
  end

  // Checker
  always @(posedge clk_i)
  begin
    if (!reset_i)
    begin
      if (cache_req_credits_full_o !== (outstanding == `UCE_MAX_CREDITS))
        report_mismatch("cache_req_credits_full_o", outstanding == `UCE_MAX_CREDITS,
                        cache_req_credits_full_o);
      if (cache_req_credits_empty_o !== (outstanding == 0))
        report_mismatch("cache_req_credits_empty_o", outstanding == 0, cache_req_credits_empty_o);
      // A full credit counter also raises busy
      if (outstanding == `UCE_MAX_CREDITS && !cache_req_busy_o)
        report_mismatch("cache_req_busy_o", 1, cache_req_busy_o);
      if (cache_req_credits_full_o)
        full_seen++;
      if (mem_fwd_v_o && cache_req_credits_full_o)
      begin
        errors++;
        $display("ERROR at %0t: forward message offered while all credits are in use", $time);
      end
      if (mem_fwd_v_o && mem_fwd_ready_and_i)
      begin
        outstanding++;
        if (exp_fwd_q.size() == 0)
        begin
          errors++;
          $display("ERROR at %0t: forward message sent with no request waiting for it", $time);
        end
        else
        begin
          mon_fwd = exp_fwd_q.pop_front();
          if (mem_fwd_msg_o !== mon_fwd.msg)
            report_mismatch("mem_fwd_msg_o", mon_fwd.msg, mem_fwd_msg_o);
          if (mem_fwd_addr_o !== mon_fwd.addr)
            report_mismatch("mem_fwd_addr_o", mon_fwd.addr, mem_fwd_addr_o);
          if (mem_fwd_way_o !== mon_fwd.way)
            report_mismatch("mem_fwd_way_o", mon_fwd.way, mem_fwd_way_o);
          if (mon_fwd.msg == e_mem_uc_wr && mem_fwd_data_o !== mon_fwd.data)
            report_mismatch("mem_fwd_data_o", mon_fwd.data, mem_fwd_data_o);
        end
      end
      if (mem_rev_v_i && mem_rev_ready_and_o)
      begin
        if (mem_rev_last_i)
          outstanding--;
        if (mem_rev_msg_i == e_mem_uc_wr)
          store_resp_cnt++;
      end
      if (tag_mem_v_o && tag_mem_yumi_i)
      begin
        if (tag_mem_op_o == e_tag_set_clear)
        begin
          if (tag_mem_index_o !== clear_cnt[`UCE_INDEX_WIDTH-1:0])
            report_mismatch("tag_mem_index_o", clear_cnt, tag_mem_index_o);
          if (!cache_req_busy_o)
            report_mismatch("cache_req_busy_o", 1, cache_req_busy_o);
          clear_cnt++;
        end
        else
        begin
          if (tag_mem_index_o !== expect_index(cur_addr))
            report_mismatch("tag_mem_index_o", expect_index(cur_addr), tag_mem_index_o);
          if (tag_mem_tag_o !== expect_tag(cur_addr))
            report_mismatch("tag_mem_tag_o", expect_tag(cur_addr), tag_mem_tag_o);
          if (tag_mem_way_o !== cur_way)
            report_mismatch("tag_mem_way_o", cur_way, tag_mem_way_o);
          tag_wr_cnt++;
        end
      end
      if (data_mem_v_o && data_mem_yumi_i)
      begin
        if (data_mem_op_o == e_data_write)
        begin
          if (data_mem_beat_o !== data_wr_cnt[`UCE_BEAT_WIDTH-1:0])
            report_mismatch("data_mem_beat_o", data_wr_cnt, data_mem_beat_o);
          if (data_mem_data_o !== expect_fill_beat(cur_addr, data_wr_cnt))
            report_mismatch("data_mem_data_o", expect_fill_beat(cur_addr, data_wr_cnt),
                            data_mem_data_o);
          if (data_mem_index_o !== expect_index(cur_addr))
            report_mismatch("data_mem_index_o", expect_index(cur_addr), data_mem_index_o);
          if (data_mem_way_o !== cur_way)
            report_mismatch("data_mem_way_o", cur_way, data_mem_way_o);
          data_wr_cnt++;
        end
        else
        begin
          if (data_mem_data_o !== expect_uncached(cur_addr))
            report_mismatch("data_mem_data_o", expect_uncached(cur_addr), data_mem_data_o);
          uc_cnt++;
        end
      end
      if (cache_req_complete_o)
        complete_cnt++;
    end
  end

  task automatic reset_counts();
    clear_cnt = 0;
    tag_wr_cnt = 0;
    data_wr_cnt = 0;
    uc_cnt = 0;
    complete_cnt = 0;
    store_resp_cnt = 0;
    full_seen = 0;
  endtask

  task automatic send_req(uce_req_type_e kind, logic [31:0] addr, logic [63:0] data,
                          logic [`UCE_WAY_WIDTH-1:0] way);
    @(posedge clk_i);
    cache_req_v_i <= 1'b1;
    cache_req_type_i <= kind;
    cache_req_addr_i <= addr;
    cache_req_data_i <= data;
    cache_req_way_i <= way;
    req_count++;
    @(posedge clk_i);
    while (!cache_req_yumi_o)
      @(posedge clk_i);
    cache_req_v_i <= 1'b0;
  endtask

  task automatic wait_complete();
    @(posedge clk_i);
    while (!cache_req_complete_o)
      @(posedge clk_i);
    @(negedge clk_i);
  endtask

  task automatic check_sweep();
    @(posedge clk_i);
    while (!cache_req_busy_o)
      @(posedge clk_i);
    while (cache_req_busy_o)
      @(posedge clk_i);
    @(negedge clk_i);
    if (clear_cnt != `UCE_SETS)
      report_mismatch("tag clear packets", `UCE_SETS, clear_cnt);
    if (!cache_req_credits_empty_o)
      report_mismatch("cache_req_credits_empty_o", 1, cache_req_credits_empty_o);
  endtask

  task automatic do_miss(logic [31:0] addr, logic [`UCE_WAY_WIDTH-1:0] way);
    reset_counts();
    cur_addr = addr;
    cur_way = way;
    exp_fwd_q.push_back({e_mem_rd, block_of(addr), 64'h0, way});
    send_req(e_req_miss_load, addr, '0, way);
    wait_complete();
    if (data_wr_cnt != `UCE_BLOCK_BEATS)
      report_mismatch("data_mem write count", `UCE_BLOCK_BEATS, data_wr_cnt);
    if (tag_wr_cnt != `UCE_BLOCK_BEATS)
      report_mismatch("tag_mem write count", `UCE_BLOCK_BEATS, tag_wr_cnt);
    if (complete_cnt != 1)
      report_mismatch("cache_req_complete_o pulses", 1, complete_cnt);
  endtask

  task automatic do_uc_load(logic [31:0] addr, logic [`UCE_WAY_WIDTH-1:0] way);
    reset_counts();
    cur_addr = addr;
    cur_way = way;
    exp_fwd_q.push_back({e_mem_uc_rd, addr, 64'h0, way});
    send_req(e_req_uc_load, addr, '0, way);
    wait_complete();
    if (uc_cnt != 1)
      report_mismatch("uncached data packets", 1, uc_cnt);
    if (data_wr_cnt != 0)
      report_mismatch("data_mem write count", 0, data_wr_cnt);
    if (complete_cnt != 1)
      report_mismatch("cache_req_complete_o pulses", 1, complete_cnt);
  endtask

  task automatic store_burst(int count);
    logic [31:0] addr;
    logic [63:0] data;
    int i;
    reset_counts();
    long_delay = 1'b1;
    for (i = 0; i < count; i++)
    begin
      addr = $urandom;
      data = {$urandom, $urandom};
      exp_fwd_q.push_back({e_mem_uc_wr, addr, data, 1'b0});
      send_req(e_req_uc_store, addr, data, 1'b0);
      @(negedge clk_i);
    end
    while (exp_fwd_q.size() != 0 || !cache_req_credits_empty_o)
      @(negedge clk_i);
    long_delay = 1'b0;
    if (store_resp_cnt != count)
      report_mismatch("store responses", count, store_resp_cnt);
    if (complete_cnt != 0)
      report_mismatch("cache_req_complete_o pulses", 0, complete_cnt);
    if (count > `UCE_MAX_CREDITS && full_seen == 0)
    begin
      errors++;
      $display("ERROR at %0t: credit counter never filled during the store burst", $time);
    end
  endtask

  initial
  begin
    seed_val = $urandom(SEED);
    clk_i = 1'b0;
    reset_i = 1'b1;
    cache_req_v_i = 1'b0;
    cache_req_type_i = e_req_miss_load;
    cache_req_addr_i = '0;
    cache_req_data_i = '0;
    cache_req_way_i = '0;
    tag_mem_yumi_i = 1'b0;
    data_mem_yumi_i = 1'b0;
    mem_fwd_ready_and_i = 1'b0;
    mem_rev_v_i = 1'b0;
    mem_rev_msg_i = e_mem_rd;
    mem_rev_addr_i = '0;
    mem_rev_way_i = '0;
    mem_rev_data_i = '0;
    mem_rev_last_i = 1'b0;
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;
    check_sweep();

    // Second pass repeats everything under random stalls
    for (int pass = 0; pass < 2; pass++)
    begin
      stall_mode = (pass == 1);
      repeat (3) do_miss($urandom, 1'($urandom_range(1, 0)));
      repeat (3) do_uc_load($urandom, 1'($urandom_range(1, 0)));
      store_burst(6);
    end

    reset_counts();
    send_req(e_req_clear, '0, '0, '0);
    check_sweep();
    do_miss($urandom, 1'b1);

    $display("Run complete: %0d requests, %0d errors", req_count, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

//--- build.f
+incdir+.
uce_pkg.sv
uce_req_decode.sv
uce_fwd_issue.sv
uce_fill_writer.sv
uce_top.sv
tb_uce.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the UCE testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_uce -f build.f -o tb_uce_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Compile failed"
  exit 1
fi

./obj_dir/tb_uce_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Finished with errors" sim.log; then
  exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0
